/* compile.f */
design/dcache_pkg.sv
design/cache_array.sv
design/miss_controller.sv
design/dcache_top.sv
verification/mem_model.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

/* verification/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    localparam int n_entries        = 19;
    localparam int stall_timeout    = 100;  // cycles
    localparam int response_timeout = 100;

    logic             clock;
    logic             reset;
    dcache_request_t  dcache_request;
    dcache_response_t dcache_response;
    logic             stall;
    mem_request_t     mem_request;
    mem_reply_t       mem_reply;
    int               error_count;
    int               check_count;
    logic             timed_out;
    dcache_request_t  stimulus [n_entries];

    dcache_top     i_dut (.*);
    mem_model      i_mem_model (.*);
    dcache_checker i_checker (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic dcache_request_t entry(input mem_op_t op, input mem_size_t size,
                                              input logic [xlen-1:0] addr,
                                              input logic [xlen-1:0] data);
        return {1'b1, op, size, addr, data};
    endfunction

    task automatic wait_for_stall_low(input int index);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (stall && cycles < stall_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (stall) begin
            timed_out = 1'b1;
            $display("timeout, stall stayed high before entry %0d", index);
        end
    endtask

    task automatic wait_for_response(input int index);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!dcache_response.valid && cycles < response_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (!dcache_response.valid) begin
            timed_out = 1'b1;
            $display("timeout, no response for entry %0d", index);
        end
    endtask

    initial begin
        reset          = 1'b1;
        dcache_request = '0;
        timed_out      = 1'b0;
        stimulus[0]  = entry(op_load,  mem_word, 32'h000, 32'h0);  // cold misses
        stimulus[1]  = entry(op_load,  mem_byte, 32'h009, 32'h0);
        stimulus[2]  = entry(op_load,  mem_half, 32'h012, 32'h0);
        stimulus[3]  = entry(op_store, mem_byte, 32'h001, 32'h0000_00a5);
        stimulus[4]  = entry(op_store, mem_half, 32'h002, 32'h0000_beef);
        stimulus[5]  = entry(op_store, mem_word, 32'h004, 32'hcafe_f00d);
        stimulus[6]  = entry(op_load,  mem_word, 32'h000, 32'h0);
        stimulus[7]  = entry(op_load,  mem_half, 32'h006, 32'h0);
        stimulus[8]  = entry(op_load,  mem_word, 32'h100, 32'h0);  // evicts dirty 0x000
        stimulus[9]  = entry(op_load,  mem_word, 32'h000, 32'h0);  // evicts clean 0x100
        stimulus[10] = entry(op_load,  mem_byte, 32'h005, 32'h0);
        stimulus[11] = entry(op_load,  mem_word, 32'h208, 32'h0);  // evicts clean 0x008
        stimulus[12] = entry(op_store, mem_word, 32'h318, 32'h1234_5678);  // store miss
        stimulus[13] = entry(op_load,  mem_byte, 32'h31a, 32'h0);
        stimulus[14] = entry(op_load,  mem_word, 32'h31c, 32'h0);
        stimulus[15] = entry(op_load,  mem_word, 32'h018, 32'h0);
        stimulus[16] = entry(op_load,  mem_half, 32'h31a, 32'h0);
        stimulus[17] = entry(op_store, mem_byte, 32'h3ff, 32'h0000_0077);
        stimulus[18] = entry(op_load,  mem_byte, 32'h3ff, 32'h0);
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            if (!timed_out) wait_for_stall_low(i);
            if (!timed_out) begin
                @(posedge clock);
                dcache_request <= stimulus[i];
                @(posedge clock);
                dcache_request <= '0;  // taken at this edge
                wait_for_response(i);
            end
        end
        repeat (4) @(posedge clock);

        $display("checks %0d errors %0d timeouts %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/dcache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_checker import dcache_pkg::*; (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire dcache_request_t  dcache_request,
    input  wire dcache_response_t dcache_response,
    input  wire logic             stall,
    input  wire mem_request_t     mem_request,
    input  wire mem_reply_t       mem_reply,
    output int                    error_count,
    output int                    check_count
);

    localparam int mem_bytes = 1024;

    logic [7:0]            shadow_mem [mem_bytes];  // memory as seen by the pipeline
    logic [tag_bits-1:0]   shadow_tag [n_lines];
    logic [n_lines-1:0]    shadow_valid;
    logic [n_lines-1:0]    shadow_dirty;
    dcache_request_t       pend;  // accepted request, not yet answered
    logic                  pend_live;
    logic                  pend_hit;
    logic                  expect_wb;
    logic [xlen-1:0]       expect_data;
    logic [xlen-1:0]       wb_addr;
    logic [xlen-1:0]       fetch_addr;
    logic [block_bits-1:0] wb_data;
    int                    wb_seen;
    int                    fetch_seen;
    int                    cycle;
    int                    accept_cycle;
    logic                  in_reset;

    initial begin
        for (int i = 0; i < mem_bytes; i++) begin
            shadow_mem[i] = i[7:0] ^ i[15:8] ^ i[23:16] ^ i[31:24] ^ 8'h5a;
        end
        in_reset = 1'b0;
        cycle    = 0;
    end

    // little endian, count bytes from addr
    function automatic logic [63:0] read_bytes(input logic [xlen-1:0] addr, input int count);
        logic [63:0] value;
        value = '0;
        for (int k = count - 1; k >= 0; k--) begin
            value = {value[55:0], shadow_mem[addr[9:0] + k]};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s expected %0h actual %0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report(input string what);
        error_count++;
        $display("ERROR %s at %0t", what, $time);
    endtask

    task automatic finish_request();
        if (pend.op == op_load) begin
            check_value("dcache_response.load_data", expect_data, dcache_response.load_data);
        end
        pend_live = 1'b0;
    endtask

    task automatic predict(input dcache_request_t req);
        logic [index_bits-1:0] index;
        logic [tag_bits-1:0]   tag;
        int                    count;
        index = req.addr[index_bits+block_offset_bits-1:block_offset_bits];
        tag   = req.addr[xlen-1:index_bits+block_offset_bits];
        count = (req.size == mem_byte) ? 1 : (req.size == mem_half) ? 2 : 4;
        if (req.addr >= mem_bytes) report("request address outside the memory window");
        pend         = req;
        pend_live    = 1'b1;
        accept_cycle = cycle;
        pend_hit     = shadow_valid[index] && (shadow_tag[index] == tag);
        expect_wb    = !pend_hit && shadow_valid[index] && shadow_dirty[index];
        wb_addr      = {shadow_tag[index], index, 3'b000};  // victim line address
        wb_data      = read_bytes(wb_addr, 8);
        fetch_addr   = {req.addr[xlen-1:block_offset_bits], 3'b000};
        wb_seen      = 0;
        fetch_seen   = 0;
        if (!pend_hit) begin
            shadow_tag[index]   = tag;
            shadow_valid[index] = 1'b1;
            shadow_dirty[index] = 1'b0;
        end
        if (req.op == op_store) begin
            for (int k = 0; k < count; k++) begin
                shadow_mem[req.addr[9:0] + k] = req.write_data[8*k +: 8];
            end
            shadow_dirty[index] = 1'b1;
        end else begin
            expect_data = read_bytes(req.addr, count);
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            in_reset     = 1'b1;
            pend_live    = 1'b0;
            shadow_valid = '0;
            shadow_dirty = '0;
            error_count  = 0;
            check_count  = 0;
        end else begin
            cycle++;
            if (in_reset) begin  // outputs as left by reset
                in_reset = 1'b0;
                check_value("dcache_response.valid", 1'b0, dcache_response.valid);
                check_value("stall", 1'b0, stall);
                check_value("mem_request.command", bus_none, mem_request.command);
            end

            // bus traffic only while a miss is outstanding
            if (mem_request.command != bus_none && (!pend_live || pend_hit)) begin
                report("bus command while no miss is outstanding");
            end else if (mem_request.command == bus_store && mem_reply.response != '0) begin
                wb_seen++;
                check_value("mem_request.addr", wb_addr, mem_request.addr);
                check_value("mem_request.data", wb_data, mem_request.data);
            end else if (mem_request.command == bus_load && mem_reply.response != '0) begin
                fetch_seen++;
                check_value("mem_request.addr", fetch_addr, mem_request.addr);
            end

            if (!pend_live) begin
                if (dcache_response.valid) report("response with no request outstanding");
            end else if (cycle == accept_cycle + 1) begin
                // a hit answers here, a miss raises stall instead
                check_value("dcache_response.valid", pend_hit, dcache_response.valid);
                check_value("stall", !pend_hit, stall);
                if (pend_hit) finish_request();
            end else if (dcache_response.valid) begin
                check_value("stall", 1'b0, stall);
                check_value("write-back count", expect_wb, wb_seen);
                check_value("line fetch count", 1, fetch_seen);
                finish_request();
            end

            if (dcache_request.valid && !stall) predict(dcache_request);
        end
    end

endmodule

`default_nettype wire

/* verification/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model import dcache_pkg::*; (
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire mem_request_t mem_request,
    output mem_reply_t        mem_reply
);

    localparam logic [31:0] seed      = 32'hef7f;
    localparam int          mem_bytes = 1024;

    logic [7:0]              mem [mem_bytes];
    logic [31:0]             rand_state;
    logic [mem_tag_bits-1:0] next_tag;     // handed out 1 to 15 in rotation
    logic [mem_tag_bits-1:0] return_tag;
    logic [xlen-1:0]         return_addr;
    int                      accept_wait;  // -1 while no command is held
    int                      return_wait;  // 0 while no load is outstanding

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [block_bits-1:0] read_line(input logic [xlen-1:0] addr);
        logic [block_bits-1:0] line;
        for (int k = 0; k < 8; k++) begin
            line[8*k +: 8] = mem[{addr[9:3], 3'b000} + k];
        end
        return line;
    endfunction

    initial begin
        for (int i = 0; i < mem_bytes; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ i[23:16] ^ i[31:24] ^ 8'h5a;
        end
        rand_state = seed;
        mem_reply  = '0;
    end

    always @(posedge clock) begin
        if (reset) begin
            mem_reply   <= '0;
            next_tag    = 1;
            accept_wait = -1;
            return_wait = 0;
        end else begin
            mem_reply.response <= '0;
            mem_reply.tag      <= '0;
            if (return_wait > 0) begin
                return_wait--;
                if (return_wait == 0) begin  // data valid for one cycle
                    mem_reply.tag  <= return_tag;
                    mem_reply.data <= read_line(return_addr);
                end
            end
            if (mem_reply.response != '0) begin
                // the cache takes the command at this edge
                accept_wait = -1;
                if (mem_request.command == bus_store) begin
                    for (int k = 0; k < 8; k++) begin
                        mem[{mem_request.addr[9:3], 3'b000} + k] = mem_request.data[8*k +: 8];
                    end
                end else begin
                    rand_state  = xorshift(rand_state);
                    return_wait = 1 + rand_state % 4;
                    return_tag  = mem_reply.response;
                    return_addr = mem_request.addr;
                end
            end else if (mem_request.command != bus_none) begin
                if (accept_wait < 0) begin
                    rand_state  = xorshift(rand_state);
                    accept_wait = rand_state % 4;  // back-pressure of 0 to 3 cycles
                end
                if (accept_wait == 0) begin
                    mem_reply.response <= next_tag;
                    next_tag = (next_tag == 15) ? 1 : next_tag + 1;
                end
                accept_wait--;
            end
        end
    end

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  wire logic             clock,
    input  wire logic             reset,

    // pipeline side
    input  wire dcache_request_t  dcache_request,
    output dcache_response_t      dcache_response,  // registered
    output logic                  stall,            // combinational

    // memory side
    output mem_request_t          mem_request,
    input  wire mem_reply_t       mem_reply
);

    logic            miss;
    victim_t         victim;
    refill_t         refill;
    dcache_request_t miss_request;
    logic [xlen-1:0] miss_addr;

    assign miss_addr = miss_request.addr;

    // lookup, store merge and the response register
    cache_array i_cache_array (
        .clock        (clock),
        .reset        (reset),
        .request      (dcache_request),
        .stall        (stall),
        .refill       (refill),
        .response     (dcache_response),
        .miss         (miss),
        .victim       (victim),
        .miss_request (miss_request)
    );

    // write-back and line fetch over the tagged bus
    miss_controller i_miss_controller (
        .clock       (clock),
        .reset       (reset),
        .miss        (miss),
        .victim      (victim),
        .miss_addr   (miss_addr),
        .mem_request (mem_request),
        .mem_reply   (mem_reply),
        .stall       (stall),
        .refill      (refill)
    );

endmodule

`default_nettype wire

/* design/miss_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_controller import dcache_pkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            miss,
    input  wire victim_t         victim,
    input  wire logic [xlen-1:0] miss_addr,
    output mem_request_t         mem_request,
    input  wire mem_reply_t      mem_reply,
    output logic                 stall,
    output refill_t              refill
);

    typedef enum logic [1:0] {
        st_idle,
        st_write_back,
        st_fetch_issue,
        st_fetch_wait
    } state_t;

    state_t state;
    state_t state_next;

    victim_t                 victim_q;  // line being evicted
    logic [mem_tag_bits-1:0] tag_q;     // tag of the outstanding fetch

    logic                      accepted;
    logic                      reply_match;
    logic [index_bits-1:0]     miss_index;
    logic [line_addr_bits-1:0] miss_line;
    logic [xlen-1:0]           victim_addr;

    // miss_addr stays steady from the cycle after the miss until the refill
    assign miss_line   = miss_addr[xlen-1:block_offset_bits];
    assign miss_index  = miss_addr[index_bits+block_offset_bits-1:block_offset_bits];
    assign victim_addr = {victim_q.tag, miss_index, {block_offset_bits{1'b0}}};

    assign accepted    = (mem_reply.response != '0);
    assign reply_match = (state == st_fetch_wait)
                      && (mem_reply.tag != '0)
                      && (mem_reply.tag == tag_q);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (miss) begin
                    state_next = victim.dirty ? st_write_back : st_fetch_issue;
                end
            end
            st_write_back: begin
                if (accepted) begin
                    state_next = st_fetch_issue;  // store is done at acceptance
                end
            end
            st_fetch_issue: begin
                if (accepted) begin
                    state_next = st_fetch_wait;
                end
            end
            st_fetch_wait: begin
                if (reply_match) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            tag_q <= '0;
        end else begin
            state <= state_next;
            if (state == st_fetch_issue && accepted) begin
                tag_q <= mem_reply.response;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_idle && miss) begin
            victim_q <= victim;
        end
    end

    // command, address and data held until the memory accepts
    always_comb begin
        mem_request.command = bus_none;
        mem_request.addr    = {miss_line, {block_offset_bits{1'b0}}};
        mem_request.data    = victim_q.block;
        case (state)
            st_write_back: begin
                mem_request.command = bus_store;
                mem_request.addr    = victim_addr;
            end
            st_fetch_issue: begin
                mem_request.command = bus_load;
            end
            default: mem_request.command = bus_none;
        endcase
    end

    assign stall = (state != st_idle);

    // one cycle packet to the array, stall drops at the same edge
    assign refill.valid     = reply_match;
    assign refill.line_addr = miss_line;
    assign refill.block     = mem_reply.data;

endmodule

`default_nettype wire

/* design/cache_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_array import dcache_pkg::*; (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire dcache_request_t  request,
    input  wire logic             stall,
    input  wire refill_t          refill,
    output dcache_response_t      response,
    output logic                  miss,
    output victim_t               victim,
    output dcache_request_t       miss_request
);

    // line state
    logic [n_lines-1:0]  valid_bits;
    logic [n_lines-1:0]  dirty_bits;
    logic [tag_bits-1:0] tags   [n_lines];
    cache_block_t        blocks [n_lines];

    logic                  accept;
    logic                  hit;
    logic [index_bits-1:0] req_index;
    logic [tag_bits-1:0]   req_tag;
    cache_block_t          req_block;

    // one write port, shared by store hits and refills
    logic                  wr_en;
    logic [index_bits-1:0] wr_index;
    logic [tag_bits-1:0]   wr_tag;
    logic                  wr_dirty;
    cache_block_t          wr_block;
    dcache_response_t      response_next;

    // pick the addressed item and zero-extend it
    function automatic logic [xlen-1:0] format_load(
        input cache_block_t                 block,
        input mem_size_t                    size,
        input logic [block_offset_bits-1:0] offset
    );
        logic [xlen-1:0] data;
        data = '0;
        case (size)
            mem_byte: data[7:0]  = block.byte_level[offset];
            mem_half: data[15:0] = block.half_level[offset[2:1]];
            default:  data       = block.word_level[offset[2]];
        endcase
        return data;
    endfunction

    // write the store data at its position in the line
    function automatic cache_block_t merge_store(
        input cache_block_t                 block,
        input mem_size_t                    size,
        input logic [block_offset_bits-1:0] offset,
        input logic [xlen-1:0]              data
    );
        cache_block_t merged;
        merged = block;
        case (size)
            mem_byte: merged.byte_level[offset]      = data[7:0];
            mem_half: merged.half_level[offset[2:1]] = data[15:0];
            default:  merged.word_level[offset[2]]   = data;
        endcase
        return merged;
    endfunction

    assign accept    = request.valid && !stall;
    assign req_index = request.addr[index_bits+block_offset_bits-1:block_offset_bits];
    assign req_tag   = request.addr[xlen-1:index_bits+block_offset_bits];
    assign req_block = blocks[req_index];

    assign hit  = valid_bits[req_index] && (tags[req_index] == req_tag);
    assign miss = accept && !hit;

    // the line at the missing index, to be written back if dirty
    assign victim.dirty = valid_bits[req_index] && dirty_bits[req_index];
    assign victim.tag   = tags[req_index];
    assign victim.block = req_block;

    always_comb begin
        wr_en         = 1'b0;
        wr_index      = req_index;
        wr_tag        = req_tag;
        wr_dirty      = 1'b1;
        wr_block      = req_block;
        response_next = '0;

        if (refill.valid) begin
            // install the fetched line, then finish the waiting request on it
            wr_en    = 1'b1;
            wr_index = refill.line_addr[index_bits-1:0];
            wr_tag   = refill.line_addr[line_addr_bits-1:index_bits];
            wr_block = refill.block;
            wr_dirty = 1'b0;
            if (miss_request.op == op_store) begin
                wr_block = merge_store(refill.block, miss_request.size,
                                       miss_request.addr[block_offset_bits-1:0],
                                       miss_request.write_data);
                wr_dirty = 1'b1;
            end
            response_next.valid     = 1'b1;
            response_next.load_data = format_load(wr_block, miss_request.size,
                                                  miss_request.addr[block_offset_bits-1:0]);
        end else if (accept && hit) begin
            response_next.valid     = 1'b1;
            response_next.load_data = format_load(req_block, request.size,
                                                  request.addr[block_offset_bits-1:0]);
            if (request.op == op_store) begin
                wr_en    = 1'b1;  // store hit dirties the line
                wr_block = merge_store(req_block, request.size,
                                       request.addr[block_offset_bits-1:0],
                                       request.write_data);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            response   <= '0;
        end else begin
            response <= response_next;
            if (wr_en) begin
                valid_bits[wr_index] <= 1'b1;
                dirty_bits[wr_index] <= wr_dirty;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            tags[wr_index]   <= wr_tag;
            blocks[wr_index] <= wr_block;
        end
        if (miss) begin
            miss_request <= request;  // held for the whole miss
        end
    end

endmodule

`default_nettype wire

/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // widths and counts
    localparam int xlen              = 32;
    localparam int block_bits        = 64;
    localparam int block_offset_bits = 3;
    localparam int n_lines           = 32;
    localparam int index_bits        = 5;
    localparam int tag_bits          = xlen - index_bits - block_offset_bits; // 24
    localparam int line_addr_bits    = xlen - block_offset_bits;              // 29
    localparam int mem_tag_bits      = 4;  // tag 0 means no response

    typedef enum logic [1:0] {
        mem_byte = 2'h0,
        mem_half = 2'h1,
        mem_word = 2'h2
    } mem_size_t;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_t;

    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // one line, read as bytes, half-words or words
    typedef union packed {
        logic [7:0][7:0]  byte_level;
        logic [3:0][15:0] half_level;
        logic [1:0][31:0] word_level;
    } cache_block_t;

    typedef struct packed {
        logic            valid;
        mem_op_t         op;
        mem_size_t       size;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] write_data;
    } dcache_request_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] load_data;  // zero-extended
    } dcache_response_t;

    typedef struct packed {
        bus_command_t          command;
        logic [xlen-1:0]       addr;
        logic [block_bits-1:0] data;
    } mem_request_t;

    typedef struct packed {
        logic [mem_tag_bits-1:0] response;  // nonzero accepts the command
        logic [mem_tag_bits-1:0] tag;       // nonzero marks returning data
        logic [block_bits-1:0]   data;
    } mem_reply_t;

    typedef struct packed {
        logic                      valid;
        logic [line_addr_bits-1:0] line_addr;
        cache_block_t              block;
    } refill_t;

    typedef struct packed {
        logic                dirty;
        logic [tag_bits-1:0] tag;
        cache_block_t        block;
    } victim_t;

endpackage

`default_nettype wire
